/* design/mem_consts.svh */
// memory subsystem constants
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

`define MEM_XLEN 64   // data word width
`define MEM_AW 32     // byte address width
`define MEM_WORDS 256 // sram depth in words
`define MEM_IDX_W 8   // word index width

// extra cycles allowed on top of the per-op budget
`define MEM_TIMEOUT_MARGIN 200

`endif

/* design/mem_pkg.sv */
// memory subsystem types
`include "mem_consts.svh"

package mem_pkg;

  typedef logic [`MEM_XLEN-1:0]   data_t;
  typedef logic [`MEM_AW-1:0]     addr_t;
  typedef logic [`MEM_XLEN/8-1:0] wmask_t;  // one bit per byte lane
  typedef logic [1:0]             size_t;   // log2 of byte count
  typedef logic [31:0]            instr_t;

  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_REQ,
    LSU_RSP
  } lsu_state_e;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_RSP
  } fetch_state_e;

endpackage

/* design/mem_bus_if.sv */
// memory request/response bus
`timescale 1ns/10ps

interface mem_bus_if
  import mem_pkg::*;
();

  logic   req_valid;
  logic   req_ready;
  logic   req_we;
  addr_t  req_addr;
  data_t  req_wdata;
  wmask_t req_wmask;

  logic   rsp_valid;
  logic   rsp_ready;
  data_t  rsp_rdata;  // old word for writes

  modport requester (
    output req_valid, req_we, req_addr, req_wdata, req_wmask, rsp_ready,
    input  req_ready, rsp_valid, rsp_rdata
  );

  modport responder (
    input  req_valid, req_we, req_addr, req_wdata, req_wmask, rsp_ready,
    output req_ready, rsp_valid, rsp_rdata
  );

endinterface

/* design/lsu.sv */
// load/store unit
`timescale 1ns/10ps
`include "mem_consts.svh"

module lsu
  import mem_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n_i,
  input  logic         rd_i,
  input  wmask_t       wmask_i,
  input  addr_t        addr_i,
  input  data_t        wdata_i,
  input  size_t        size_i,
  input  logic         sext_i,
  output data_t        rdata_o,
  output logic         wait_o,
  mem_bus_if.requester bus
);

  lsu_state_e state_q;
  logic       start;
  logic       is_wr;
  logic       rsp_hs;
  logic [2:0] off_q;
  size_t      size_q;
  logic       sext_q;
  logic       we_q;
  addr_t      addr_q;
  data_t      wdata_q;
  wmask_t     wmask_q;
  data_t      shifted;
  data_t      load_val;

  assign is_wr  = |wmask_i;  // mask wins over the read strobe
  assign start  = (rd_i | is_wr) & ~wait_o;
  assign rsp_hs = bus.rsp_valid & bus.rsp_ready;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= LSU_IDLE;
      wait_o  <= 1'b0;
      rdata_o <= '0;
    end else begin
      case (state_q)
        LSU_IDLE: begin
          if (start) begin
            state_q <= LSU_REQ;
            wait_o  <= 1'b1;
          end
        end
        LSU_REQ: begin
          if (bus.req_ready) state_q <= LSU_RSP;
        end
        LSU_RSP: begin
          if (rsp_hs) begin
            state_q <= LSU_IDLE;
            wait_o  <= 1'b0;
            if (!we_q) rdata_o <= load_val;
          end
        end
        default: state_q <= LSU_IDLE;
      endcase
    end
  end

  // lane alignment of the request
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q  <= {addr_i[`MEM_AW-1:3], 3'b000};
      wdata_q <= wdata_i << {addr_i[2:0], 3'b000};
      wmask_q <= wmask_i << addr_i[2:0];
      we_q    <= is_wr;
      off_q   <= addr_i[2:0];
      size_q  <= size_i;
      sext_q  <= sext_i;
    end
  end

  assign bus.req_valid = (state_q == LSU_REQ);
  assign bus.req_we    = we_q;
  assign bus.req_addr  = addr_q;
  assign bus.req_wdata = wdata_q;
  assign bus.req_wmask = wmask_q;
  assign bus.rsp_ready = (state_q == LSU_RSP);

  assign shifted = bus.rsp_rdata >> {off_q, 3'b000};

  always_comb begin
    case (size_q)
      2'd0: load_val = {{(`MEM_XLEN-8){sext_q & shifted[7]}}, shifted[7:0]};
      2'd1: load_val = {{(`MEM_XLEN-16){sext_q & shifted[15]}}, shifted[15:0]};
      2'd2: load_val = {{(`MEM_XLEN-32){sext_q & shifted[31]}}, shifted[31:0]};
      default: load_val = shifted;  // double, nothing to extend
    endcase
  end

  // access must stay inside one 8-byte word
  a_no_cross: assert property (@(posedge clk) disable iff (!rst_n_i)
    start |-> ({1'b0, addr_i[2:0]} + (4'd1 << size_i)) <= 4'd8);

  a_wait_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
    (state_q != LSU_IDLE) |-> wait_o);

endmodule

/* design/fetch_unit.sv */
// instruction fetch unit
`timescale 1ns/10ps

module fetch_unit
  import mem_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n_i,
  input  logic         req_i,
  input  addr_t        pc_i,
  output instr_t       instr_o,
  output logic         wait_o,
  mem_bus_if.requester bus
);

  fetch_state_e state_q;
  logic         start;
  logic         hi_q;  // pc bit 2, picks the upper half
  addr_t        addr_q;

  assign start = req_i & ~wait_o;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= FETCH_IDLE;
      wait_o  <= 1'b0;
      instr_o <= '0;
    end else begin
      case (state_q)
        FETCH_IDLE: begin
          if (start) begin
            state_q <= FETCH_REQ;
            wait_o  <= 1'b1;
          end
        end
        FETCH_REQ: begin
          if (bus.req_ready) state_q <= FETCH_RSP;
        end
        FETCH_RSP: begin
          if (bus.rsp_valid) begin
            state_q <= FETCH_IDLE;
            wait_o  <= 1'b0;
            instr_o <= hi_q ? bus.rsp_rdata[63:32] : bus.rsp_rdata[31:0];
          end
        end
        default: state_q <= FETCH_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= {pc_i[31:3], 3'b000};
      hi_q   <= pc_i[2];
    end
  end

  assign bus.req_valid = (state_q == FETCH_REQ);
  assign bus.req_addr  = addr_q;
  assign bus.req_we    = 1'b0;  // read only
  assign bus.req_wdata = '0;
  assign bus.req_wmask = '0;
  assign bus.rsp_ready = (state_q == FETCH_RSP);

  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
    start |-> (pc_i[1:0] == 2'b00));

endmodule

/* design/bus_arbiter.sv */
// round-robin memory bus arbiter
`timescale 1ns/10ps

module bus_arbiter
  import mem_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n_i,
  mem_bus_if.responder fetch_port,
  mem_bus_if.responder lsu_port,
  mem_bus_if.requester mem_port
);

  // owner encoding: 1 = lsu, 0 = fetch
  logic locked_q;
  logic owner_q;
  logic last_q;
  logic sel;
  logic cur;
  logic accept;
  logic rsp_done;

  // on a tie grant the port not served last
  assign sel = lsu_port.req_valid & (~fetch_port.req_valid | ~last_q);
  assign cur = locked_q ? owner_q : sel;

  assign mem_port.req_valid = cur ? lsu_port.req_valid : fetch_port.req_valid;
  assign mem_port.req_we    = cur ? lsu_port.req_we    : fetch_port.req_we;
  assign mem_port.req_addr  = cur ? lsu_port.req_addr  : fetch_port.req_addr;
  assign mem_port.req_wdata = cur ? lsu_port.req_wdata : fetch_port.req_wdata;
  assign mem_port.req_wmask = cur ? lsu_port.req_wmask : fetch_port.req_wmask;

  assign lsu_port.req_ready   = cur & mem_port.req_ready;
  assign fetch_port.req_ready = ~cur & mem_port.req_ready;

  // response only reaches the owner
  assign lsu_port.rsp_valid   = locked_q & owner_q & mem_port.rsp_valid;
  assign fetch_port.rsp_valid = locked_q & ~owner_q & mem_port.rsp_valid;
  assign lsu_port.rsp_rdata   = mem_port.rsp_rdata;
  assign fetch_port.rsp_rdata = mem_port.rsp_rdata;
  assign mem_port.rsp_ready   = locked_q &
                                (owner_q ? lsu_port.rsp_ready : fetch_port.rsp_ready);

  assign accept   = mem_port.req_valid & mem_port.req_ready;
  assign rsp_done = mem_port.rsp_valid & mem_port.rsp_ready;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      locked_q <= 1'b0;
      owner_q  <= 1'b0;
      last_q   <= 1'b0;
    end else begin
      if (rsp_done) locked_q <= 1'b0;
      if (accept) begin
        locked_q <= 1'b1;
        owner_q  <= cur;
        last_q   <= cur;
      end
    end
  end

  a_owner_held: assert property (@(posedge clk) disable iff (!rst_n_i)
    (locked_q & ~rsp_done) |=> $stable(owner_q));

endmodule

/* design/data_sram.sv */
// byte-masked data sram
`timescale 1ns/10ps
`include "mem_consts.svh"

module data_sram
  import mem_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n_i,
  mem_bus_if.responder bus
);

  data_t                 mem [`MEM_WORDS];
  logic [`MEM_IDX_W-1:0] idx;
  logic                  accept;
  logic                  rsp_valid_q;
  data_t                 rdata_q;

  assign idx    = bus.req_addr[`MEM_IDX_W+2:3];  // upper bits wrap
  assign accept = bus.req_valid & bus.req_ready;

  assign bus.req_ready = ~rsp_valid_q;  // one response in flight
  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp_rdata = rdata_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      if (accept) begin
        rsp_valid_q <= 1'b1;
      end else if (bus.rsp_ready) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rdata_q <= mem[idx];  // word before the write
      if (bus.req_we) begin
        for (int b = 0; b < `MEM_XLEN/8; b++) begin
          if (bus.req_wmask[b]) mem[idx][8*b +: 8] <= bus.req_wdata[8*b +: 8];
        end
      end
    end
  end

  // response held with its data until taken
  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    (bus.rsp_valid & ~bus.rsp_ready) |=> (bus.rsp_valid & $stable(bus.rsp_rdata)));

endmodule

/* design/mem_subsys_top.sv */
// memory subsystem top
`timescale 1ns/10ps

module mem_subsys_top
  import mem_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n_i,
  // load/store side
  input  logic   lsu_rd_i,
  input  wmask_t lsu_wmask_i,
  input  addr_t  lsu_addr_i,
  input  data_t  lsu_wdata_i,
  input  size_t  lsu_size_i,
  input  logic   lsu_sext_i,
  output data_t  lsu_rdata_o,
  output logic   lsu_wait_o,
  // fetch side
  input  logic   fetch_req_i,
  input  addr_t  fetch_pc_i,
  output instr_t fetch_instr_o,
  output logic   fetch_wait_o
);

  mem_bus_if lsu_bus ();
  mem_bus_if fetch_bus ();
  mem_bus_if mem_bus ();

  lsu u_lsu (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .rd_i    (lsu_rd_i),
    .wmask_i (lsu_wmask_i),
    .addr_i  (lsu_addr_i),
    .wdata_i (lsu_wdata_i),
    .size_i  (lsu_size_i),
    .sext_i  (lsu_sext_i),
    .rdata_o (lsu_rdata_o),
    .wait_o  (lsu_wait_o),
    .bus     (lsu_bus)
  );

  fetch_unit u_fetch (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_i   (fetch_req_i),
    .pc_i    (fetch_pc_i),
    .instr_o (fetch_instr_o),
    .wait_o  (fetch_wait_o),
    .bus     (fetch_bus)
  );

  bus_arbiter u_arb (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .fetch_port (fetch_bus),
    .lsu_port   (lsu_bus),
    .mem_port   (mem_bus)
  );

  data_sram u_sram (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .bus     (mem_bus)
  );

endmodule

/* bench/mem_subsys_tb.sv */
// memory subsystem testbench
`timescale 1ns/10ps
`include "mem_consts.svh"

module mem_subsys_tb
  import mem_pkg::*;
();

  localparam int N_FILL      = `MEM_WORDS;
  localparam int N_LOAD      = 120;  // per sext setting
  localparam int N_PART      = 60;   // store plus reload pairs
  localparam int N_FETCH     = 60;
  localparam int N_CONT      = 80;
  localparam int N_OPS       = N_FILL + 2 * N_LOAD + 2 * N_PART + N_FETCH + N_CONT;
  localparam int CYCLE_LIMIT = N_OPS * 20 + `MEM_TIMEOUT_MARGIN;

  logic   clk;
  logic   rst_n_i;
  logic   lsu_rd_i;
  wmask_t lsu_wmask_i;
  addr_t  lsu_addr_i;
  data_t  lsu_wdata_i;
  size_t  lsu_size_i;
  logic   lsu_sext_i;
  data_t  lsu_rdata_o;
  logic   lsu_wait_o;
  logic   fetch_req_i;
  addr_t  fetch_pc_i;
  instr_t fetch_instr_o;
  logic   fetch_wait_o;

  logic [7:0]  shadow [`MEM_WORDS * 8];  // byte image of the sram
  logic [31:0] rng_state = 32'hc3ca_7925;
  bit          lsu_rd_q [$];
  data_t       lsu_exp_q [$];
  instr_t      fetch_exp_q [$];
  int          n_checks = 0;
  int          n_errors = 0;
  int          n_timeouts = 0;
  int          cycles = 0;

  mem_subsys_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic data_t rand_data();
    return {next_rand(), next_rand()};
  endfunction

  function automatic size_t rand_size();
    logic [31:0] r;
    r = next_rand();
    return r[31:30];
  endfunction

  // offset kept so the access fits in its word
  function automatic addr_t rand_addr(input size_t size);
    logic [31:0] r;
    logic [2:0]  off;
    int          n;
    r   = next_rand();
    n   = 1 << size;
    off = 3'(r[15:8] % (9 - n));
    return {21'd0, r[23:16], off};
  endfunction

  function automatic addr_t rand_pc();
    logic [31:0] r;
    r = next_rand();
    return {21'd0, r[23:16], r[24], 2'b00};
  endfunction

  // expected load value built from the shadow bytes
  function automatic data_t ref_load(input addr_t addr, input size_t size, input logic sext);
    data_t v;
    int    n;
    logic  sign;
    n    = 1 << size;
    v    = '0;
    sign = shadow[addr[10:0] + 11'(n - 1)][7];
    for (int i = 7; i >= 0; i--) begin
      v = v << 8;
      if (i < n) v[7:0] = shadow[addr[10:0] + 11'(i)];
      else if (sext) v[7:0] = {8{sign}};
    end
    return v;
  endfunction

  function automatic instr_t ref_instr(input addr_t pc);
    return {shadow[pc[10:0] + 11'd3], shadow[pc[10:0] + 11'd2],
            shadow[pc[10:0] + 11'd1], shadow[pc[10:0]]};
  endfunction

  task automatic check_value(input string name, input data_t got, input data_t exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic issue_load(input addr_t addr, input size_t size, input logic sext);
    lsu_rd_q.push_back(1'b1);
    lsu_exp_q.push_back(ref_load(addr, size, sext));
    lsu_rd_i    <= 1'b1;
    lsu_wmask_i <= '0;
    lsu_addr_i  <= addr;
    lsu_size_i  <= size;
    lsu_sext_i  <= sext;
  endtask

  task automatic issue_store(input addr_t addr, input size_t size, input data_t wdata);
    data_t d;
    int    n;
    n = 1 << size;
    d = wdata;
    for (int i = 0; i < n; i++) begin
      shadow[addr[10:0] + 11'(i)] = d[7:0];
      d = d >> 8;
    end
    lsu_rd_q.push_back(1'b0);
    lsu_exp_q.push_back('0);
    lsu_rd_i    <= 1'b0;
    lsu_wmask_i <= wmask_t'((9'd1 << n) - 9'd1);  // lsu moves it to the lanes
    lsu_addr_i  <= addr;
    lsu_wdata_i <= wdata;
    lsu_size_i  <= size;
  endtask

  task automatic issue_fetch(input addr_t pc);
    fetch_exp_q.push_back(ref_instr(pc));
    fetch_req_i <= 1'b1;
    fetch_pc_i  <= pc;
  endtask

  // drop the strobes, then wait until both units are idle
  task automatic finish_op();
    @(posedge clk);
    lsu_rd_i    <= 1'b0;
    lsu_wmask_i <= '0;
    fetch_req_i <= 1'b0;
    do @(posedge clk); while (lsu_wait_o || fetch_wait_o);
  endtask

  task automatic report_result();
    $display("checks %0d, mismatches %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
  endtask

  // lsu results, sampled mid-cycle after wait falls
  initial begin
    data_t exp;
    bit    is_rd;
    @(posedge rst_n_i);
    forever begin
      @(negedge lsu_wait_o);
      @(negedge clk);
      if (lsu_rd_q.size() == 0) begin
        n_errors++;
        $display("ERROR: lsu finished with no request outstanding");
      end else begin
        is_rd = lsu_rd_q.pop_front();
        exp   = lsu_exp_q.pop_front();
        if (is_rd) check_value("lsu_rdata_o", lsu_rdata_o, exp);
      end
    end
  end

  initial begin
    @(posedge rst_n_i);
    forever begin
      @(negedge fetch_wait_o);
      @(negedge clk);
      if (fetch_exp_q.size() == 0) begin
        n_errors++;
        $display("ERROR: fetch finished with no request outstanding");
      end else begin
        check_value("fetch_instr_o", data_t'(fetch_instr_o), data_t'(fetch_exp_q.pop_front()));
      end
    end
  end

  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    n_timeouts++;
    $display("ERROR: run exceeded %0d cycles, a transaction never finished", CYCLE_LIMIT);
    report_result();
    $finish;
  end

  initial begin
    size_t       sz;
    addr_t       a;
    logic [31:0] r;
    rst_n_i     <= 1'b0;
    lsu_rd_i    <= 1'b0;
    lsu_wmask_i <= '0;
    lsu_addr_i  <= '0;
    lsu_wdata_i <= '0;
    lsu_size_i  <= '0;
    lsu_sext_i  <= 1'b0;
    fetch_req_i <= 1'b0;
    fetch_pc_i  <= '0;
    repeat (10) @(posedge clk);
    rst_n_i <= 1'b1;

    @(negedge clk);
    check_value("lsu_wait_o", data_t'(lsu_wait_o), '0);
    check_value("fetch_wait_o", data_t'(fetch_wait_o), '0);
    check_value("lsu_rdata_o", lsu_rdata_o, '0);
    check_value("fetch_instr_o", data_t'(fetch_instr_o), '0);

    for (int w = 0; w < N_FILL; w++) begin
      @(posedge clk);
      issue_store(addr_t'(w * 8), 2'd3, rand_data());
      finish_op();
    end

    // zero extended first, then sign extended
    for (int s = 0; s < 2; s++) begin
      repeat (N_LOAD) begin
        sz = rand_size();
        @(posedge clk);
        issue_load(rand_addr(sz), sz, s[0]);
        finish_op();
      end
    end

    repeat (N_PART) begin
      sz = size_t'(next_rand() % 3);
      a  = rand_addr(sz);
      @(posedge clk);
      issue_store(a, sz, rand_data());
      finish_op();
      @(posedge clk);
      issue_load({a[31:3], 3'b000}, 2'd3, 1'b0);  // whole word back
      finish_op();
    end

    repeat (N_FETCH) begin
      @(posedge clk);
      issue_fetch(rand_pc());
      finish_op();
    end

    repeat (N_CONT) begin
      sz = rand_size();
      a  = rand_addr(sz);
      r  = next_rand();
      @(posedge clk);
      if (r[31]) begin
        a[10] = 1'b0;  // stores lower half, fetches upper half
        issue_store(a, sz, rand_data());
      end else begin
        issue_load(a, sz, r[30]);
      end
      issue_fetch(rand_pc() | 32'h400);
      finish_op();
    end

    repeat (4) @(posedge clk);
    report_result();
    $finish;
  end

endmodule

/* verilog.f */
+incdir+design
design/mem_pkg.sv
design/mem_bus_if.sv
design/lsu.sv
design/fetch_unit.sv
design/bus_arbiter.sv
design/data_sram.sv
design/mem_subsys_top.sv
bench/mem_subsys_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module mem_subsys_tb -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
